/* source/lspc_defines.svh */
`ifndef LSPC_DEFINES_SVH
`define LSPC_DEFINES_SVH

// Raster geometry, NTSC timing
`define LSPC_H_TOTAL        384     // Pixels per line, 4 clocks each
`define LSPC_V_TOTAL        264     // Lines per frame

// Sync and blanking limits
`define LSPC_HSYNC_END      29      // First pixel past the sync pulse
`define LSPC_VBLANK_START   240     // First blanked line
`define LSPC_CHBL_START     320     // First blanked pixel of a line

// Slow VRAM geometry
`define LSPC_VRAM_AW        15      // 32K words

// Fix map lives at word 0x7000 of slow VRAM
// Map address is base, column, row
`define LSPC_FIX_BASE       4'b1110

`endif

/* source/timingPkg.sv */
`include "lspc_defines.svh"

package timingPkg;

	// Pixel position within a line
	typedef logic [$clog2(`LSPC_H_TOTAL)-1:0] hCountT;

	// Line number within a frame
	typedef logic [$clog2(`LSPC_V_TOTAL)-1:0] vCountT;

	// Raster position broadcast to every block
	typedef struct packed
	{
		hCountT hCount;         // Current pixel
		vCountT vCount;         // Current line
		logic [1:0] pixPhase;   // Clock within the pixel
	} rasterT;

endpackage

/* source/vramPkg.sv */
`include "lspc_defines.svh"

package vramPkg;

	// Word address into slow VRAM
	typedef logic [`LSPC_VRAM_AW-1:0] vramAddrT;

	// Request from a peer, held until ack
	typedef struct packed
	{
		logic valid;
		logic write;            // Read when low
		vramAddrT addr;
		logic [15:0] wdata;
	} vramReqT;

	// Response back to a peer
	typedef struct packed
	{
		logic ack;              // Single cycle
		logic [15:0] rdata;     // Valid with ack
	} vramRspT;

	// Fix map entry fields
	typedef struct packed
	{
		logic [3:0] palette;
		logic [11:0] tile;
	} fixFieldsT;

	// Same VRAM word, raw for the CPU or split for the fix fetcher
	typedef union packed
	{
		logic [15:0] raw;
		fixFieldsT fix;
	} fixEntryU;

endpackage

/* source/videoSync.sv */
`include "lspc_defines.svh"

module videoSync
(
	input  logic CLK_24M,
	input  logic RESETP,
	output timingPkg::rasterT raster,
	output logic hsync,
	output logic vblank,
	output logic chbl
);

	timingPkg::hCountT hNext;   // Counter values after this edge
	timingPkg::vCountT vNext;
	logic pixEnd;               // Last clock of a pixel
	logic lineEnd;              // Last clock of a line

	assign pixEnd = (raster.pixPhase == 2'd3);
	assign lineEnd = pixEnd && (raster.hCount == timingPkg::hCountT'(`LSPC_H_TOTAL - 1));

	always_comb
	begin
		hNext = raster.hCount;
		vNext = raster.vCount;
		if (lineEnd)
			hNext = '0;
		else if (pixEnd)
			hNext = raster.hCount + 1'b1;
		// Line counter steps on the H wrap
		if (lineEnd)
		begin
			if (raster.vCount == timingPkg::vCountT'(`LSPC_V_TOTAL - 1))
				vNext = '0;
			else
				vNext = raster.vCount + 1'b1;
		end
	end

	// Flags decoded from the next counts, so they line up with the counters
	always_ff @(posedge CLK_24M)
	begin
		if (RESETP)
		begin
			raster <= '0;
			hsync <= 1'b1;      // Pixel 0 is inside the pulse
			vblank <= 1'b0;
			chbl <= 1'b0;
		end
		else
		begin
			raster.pixPhase <= raster.pixPhase + 2'd1;  // Free running 24/4
			raster.hCount <= hNext;
			raster.vCount <= vNext;
			hsync <= (hNext < `LSPC_HSYNC_END);
			vblank <= (vNext >= `LSPC_VBLANK_START);
			chbl <= (hNext >= `LSPC_CHBL_START);
		end
	end

endmodule

/* source/vramSlow.sv */
`include "lspc_defines.svh"

module vramSlow
(
	input  logic CLK_24M,
	input  logic en,
	input  logic we,
	input  vramPkg::vramAddrT addr,
	input  logic [15:0] wdata,
	output logic [15:0] rdata
);

	logic [15:0] mem [0:(1 << `LSPC_VRAM_AW)-1];    // 32K x 16

	// Read returns the old word on a write cycle
	always_ff @(posedge CLK_24M)
	begin
		if (en)
		begin
			if (we)
				mem[addr] <= wdata;
			rdata <= mem[addr];
		end
	end

endmodule

/* source/slowCycle.sv */
`include "lspc_defines.svh"

module slowCycle
(
	input  logic CLK_24M,
	input  logic RESETP,
	input  timingPkg::rasterT raster,
	input  vramPkg::vramReqT fixReq,
	output vramPkg::vramRspT fixRsp,
	input  vramPkg::vramReqT cpuReq,
	output vramPkg::vramRspT cpuRsp
);

	vramPkg::vramReqT slotReq;  // Request of the granted peer
	logic fixGrant;
	logic cpuGrant;
	logic memEn;
	logic fixAckQ;              // Remembers who owned the last slot
	logic cpuAckQ;
	logic [15:0] memRdata;

	// Phase 0 fix, phase 2 CPU, 1 and 3 idle
	assign fixGrant = (raster.pixPhase == 2'd0) && fixReq.valid;
	assign cpuGrant = (raster.pixPhase == 2'd2) && cpuReq.valid;
	assign memEn = fixGrant || cpuGrant;

	assign slotReq = fixGrant ? fixReq : cpuReq;

	vramSlow vramSlow_inst
	(
		.CLK_24M(CLK_24M),
		.en(memEn),
		.we(memEn && slotReq.write),
		.addr(slotReq.addr),
		.wdata(slotReq.wdata),
		.rdata(memRdata)
	);

	// Ack lands with the read data, one cycle after the slot
	always_ff @(posedge CLK_24M)
	begin
		if (RESETP)
		begin
			fixAckQ <= 1'b0;
			cpuAckQ <= 1'b0;
		end
		else
		begin
			fixAckQ <= fixGrant;
			cpuAckQ <= cpuGrant;
		end
	end

	// Read data goes to both, only the acked one looks
	assign fixRsp = '{ack: fixAckQ, rdata: memRdata};
	assign cpuRsp = '{ack: cpuAckQ, rdata: memRdata};

endmodule

/* source/lspcRegs.sv */
`include "lspc_defines.svh"

module lspcRegs
(
	input  logic CLK_24M,
	input  logic RESETP,
	input  logic [2:0] cpuAddr,
	input  logic [15:0] cpuDataIn,
	input  logic cpuWe,
	input  logic cpuOe,
	output logic [15:0] cpuDataOut,
	output logic vramBusy,
	input  timingPkg::rasterT raster,
	output vramPkg::vramReqT cpuReq,
	input  vramPkg::vramRspT cpuRsp
);

	vramPkg::vramAddrT vramAddr;    // Current CPU VRAM pointer
	logic [15:0] vramMod;           // Step after each data write
	vramPkg::fixEntryU readBuf;     // Last prefetched word
	logic stepPending;              // Write acked, prefetch not yet issued
	logic vramStrobe;               // Accepted access to reg 0 or 1
	logic [15:0] readMux;

	assign vramStrobe = cpuWe && !vramBusy && (cpuAddr == 3'd0 || cpuAddr == 3'd1);

	// Pending access latch, set by the strobe, cleared by the ack pulse
	always_ff @(posedge CLK_24M)
	begin
		if (RESETP)
		begin
			cpuReq <= '0;
			vramAddr <= '0;
			vramMod <= '0;
			vramBusy <= 1'b0;
			stepPending <= 1'b0;
		end
		else
		begin
			if (cpuRsp.ack)
			begin
				cpuReq.valid <= 1'b0;
				if (cpuReq.write)
				begin
					vramAddr <= vramAddr + vramMod[`LSPC_VRAM_AW-1:0];  // 15-bit wrap
					stepPending <= 1'b1;
				end
				else
					vramBusy <= 1'b0;   // Prefetch is always the last access
			end
			else if (stepPending)
			begin
				cpuReq.valid <= 1'b1;   // Auto prefetch at the new pointer
				cpuReq.write <= 1'b0;
				cpuReq.addr <= vramAddr;
				stepPending <= 1'b0;
			end
			else if (vramStrobe)
			begin
				vramBusy <= 1'b1;
				cpuReq.valid <= 1'b1;
				if (cpuAddr == 3'd0)
				begin
					vramAddr <= cpuDataIn[`LSPC_VRAM_AW-1:0];
					cpuReq.write <= 1'b0;
					cpuReq.addr <= cpuDataIn[`LSPC_VRAM_AW-1:0];
				end
				else
				begin
					cpuReq.write <= 1'b1;
					cpuReq.addr <= vramAddr;
					cpuReq.wdata <= cpuDataIn;
				end
			end

			if (cpuWe && cpuAddr == 3'd2)
				vramMod <= cpuDataIn;
		end
	end

	always_comb
	begin
		case (cpuAddr)
			3'd0, 3'd1: readMux = readBuf.raw;
			3'd2: readMux = vramMod;
			3'd3: readMux = {raster.vCount, 7'd0};  // Live line count
			default: readMux = 16'h0000;
		endcase
	end

	always_ff @(posedge CLK_24M)
	begin
		if (cpuRsp.ack && !cpuReq.write)
			readBuf.raw <= cpuRsp.rdata;
		if (cpuOe)
			cpuDataOut <= readMux;  // Valid the cycle after the strobe
	end

endmodule

/* source/fixFetch.sv */
`include "lspc_defines.svh"

module fixFetch
(
	input  logic CLK_24M,
	input  logic RESETP,
	input  timingPkg::rasterT raster,
	output vramPkg::vramReqT fixReq,
	input  vramPkg::vramRspT fixRsp,
	output logic [15:0] fixRomAddr,
	output logic [3:0] fixPal
);

	vramPkg::fixEntryU entry;   // Returned map word
	logic [11:0] tileQ;         // Tile of the current column
	logic columnStart;          // First clock of an 8-pixel column

	assign columnStart = (raster.hCount[2:0] == 3'd0) && (raster.pixPhase == 2'd0);
	assign entry.raw = fixRsp.rdata;

	// Read only, write and wdata stay cleared
	always_ff @(posedge CLK_24M)
	begin
		if (RESETP)
			fixReq <= '0;
		else if (fixRsp.ack)
			fixReq.valid <= 1'b0;
		else if (columnStart)
		begin
			fixReq.valid <= 1'b1;   // Served in phase 0 of the next pixel
			fixReq.addr <= {`LSPC_FIX_BASE, raster.hCount[8:3], raster.vCount[7:3]};
		end
	end

	always_ff @(posedge CLK_24M)
	begin
		if (fixRsp.ack)
		begin
			tileQ <= entry.fix.tile;
			fixPal <= entry.fix.palette;
		end
	end

	// Half-tile and row bits follow the raster
	assign fixRomAddr = {raster.hCount[2], raster.vCount[2:0], tileQ};

endmodule

/* source/lspcTop.sv */
`include "lspc_defines.svh"

module lspcTop
(
	input  logic CLK_24M,
	input  logic RESETP,
	input  logic [2:0] cpuAddr,
	input  logic [15:0] cpuDataIn,
	input  logic cpuWe,
	input  logic cpuOe,
	output logic [15:0] cpuDataOut,
	output logic vramBusy,
	output logic hsync,
	output logic vblank,
	output logic chbl,
	output timingPkg::hCountT hCount,
	output timingPkg::vCountT vCount,
	output logic [15:0] fixRomAddr,
	output logic [3:0] fixPal
);

	timingPkg::rasterT raster;
	vramPkg::vramReqT cpuReq;
	vramPkg::vramRspT cpuRsp;
	vramPkg::vramReqT fixReq;
	vramPkg::vramRspT fixRsp;

	videoSync videoSync_inst (.CLK_24M, .RESETP, .raster, .hsync, .vblank, .chbl);

	lspcRegs lspcRegs_inst
	(
		.CLK_24M, .RESETP, .cpuAddr, .cpuDataIn, .cpuWe, .cpuOe,
		.cpuDataOut, .vramBusy, .raster, .cpuReq, .cpuRsp
	);

	fixFetch fixFetch_inst (.CLK_24M, .RESETP, .raster, .fixReq, .fixRsp, .fixRomAddr, .fixPal);

	// Sole owner of the slow VRAM port
	slowCycle slowCycle_inst (.CLK_24M, .RESETP, .raster, .fixReq, .fixRsp, .cpuReq, .cpuRsp);

	assign hCount = raster.hCount;
	assign vCount = raster.vCount;

endmodule

/* verif/lspcTb.sv */
`include "lspc_defines.svh"

module lspcTb;

	localparam int TIMEOUT_CYCLES = 1000000;   // Two frames of 405504 plus margin
	localparam int LINE_CYCLES = `LSPC_H_TOTAL * 4;

	logic CLK_24M;
	logic RESETP;
	logic [2:0] cpuAddr;
	logic [15:0] cpuDataIn;
	logic cpuWe;
	logic cpuOe;
	logic [15:0] cpuDataOut;
	logic vramBusy;
	logic hsync;
	logic vblank;
	logic chbl;
	timingPkg::hCountT hCount;
	timingPkg::vCountT vCount;
	logic [15:0] fixRomAddr;
	logic [3:0] fixPal;

	logic [15:0] shadow [0:(1 << `LSPC_VRAM_AW)-1];   // Model of slow VRAM
	logic [`LSPC_VRAM_AW-1:0] tbAddr;                   // Expected CPU pointer
	logic [15:0] tbMod;
	int seed;
	int cycleCount;
	logic fixDone;              // Fix watcher finished, traffic may stop
	logic [5:0] fixCol [0:3];   // Map entries placed for the fetch checks
	logic [4:0] fixRow [0:3];
	logic [15:0] fixWord [0:3];

	lspcTop lspcTop_inst
	(
		.CLK_24M(CLK_24M), .RESETP(RESETP), .cpuAddr(cpuAddr), .cpuDataIn(cpuDataIn),
		.cpuWe(cpuWe), .cpuOe(cpuOe), .cpuDataOut(cpuDataOut), .vramBusy(vramBusy),
		.hsync(hsync), .vblank(vblank), .chbl(chbl), .hCount(hCount), .vCount(vCount),
		.fixRomAddr(fixRomAddr), .fixPal(fixPal)
	);

	initial
	begin
		CLK_24M = 1'b0;
		forever #4 CLK_24M = ~CLK_24M;
	end

	// Watchdog
	always @(posedge CLK_24M)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES)
			reportFailure("simulation timed out before all tests finished");
	end

	task automatic abortRun();
		$display(">>> FAIL");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic reportFailure(input string what);
		$display("ERROR at time %0t: %s", $time, what);
		abortRun();
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("FAILED time=%0t %s expected 0x%0h actual 0x%0h",
				$time, name, expected, actual);
			abortRun();
		end
	endtask

	function automatic logic [15:0] randomWord();
		return 16'($random(seed));
	endfunction

	// One-cycle register strobe, returns on the edge that samples it
	task automatic writeReg(input logic [2:0] addr, input logic [15:0] data);
		@(posedge CLK_24M);
		cpuAddr <= addr;
		cpuDataIn <= data;
		cpuWe <= 1'b1;
		@(posedge CLK_24M);
		cpuWe <= 1'b0;
	endtask

	task automatic readReg(input logic [2:0] addr, output logic [15:0] data);
		@(posedge CLK_24M);
		cpuAddr <= addr;
		cpuOe <= 1'b1;
		@(posedge CLK_24M);
		cpuOe <= 1'b0;
		@(posedge CLK_24M);
		data = cpuDataOut;      // Registered on the strobe edge
	endtask

	// Busy must rise after the strobe, then fall within the worst-case latency
	task automatic waitIdle();
		int n;
		n = 0;
		@(posedge CLK_24M);
		checkValue("vramBusy", 1, vramBusy);
		while (vramBusy)
		begin
			@(posedge CLK_24M);
			n++;
			if (n > 16)
				reportFailure("VRAM access never finished, vramBusy stuck high");
		end
	endtask

	task automatic setMod(input logic [15:0] m);
		writeReg(3'd2, m);
		tbMod = m;
	endtask

	task automatic setAddr(input logic [`LSPC_VRAM_AW-1:0] a);
		writeReg(3'd0, {1'b0, a});
		waitIdle();
		tbAddr = a;
	endtask

	task automatic writeData(input logic [15:0] d);
		writeReg(3'd1, d);
		waitIdle();
		shadow[tbAddr] = d;
		tbAddr = tbAddr + tbMod[`LSPC_VRAM_AW-1:0];   // Wraps at 15 bits
	endtask

	task automatic readCheck();
		logic [15:0] v;
		readReg(3'd1, v);
		checkValue("cpuDataOut", shadow[tbAddr], v);
	endtask

	// Cycles until the next first pixel of a line
	task automatic countToWrap(output int n);
		n = 0;
		while (hCount != `LSPC_H_TOTAL - 1)
		begin
			@(posedge CLK_24M);
			n++;
		end
		while (hCount != 0)
		begin
			@(posedge CLK_24M);
			n++;
		end
	endtask

	task automatic checkRasterFlags();
		checkValue("vblank", vCount >= `LSPC_VBLANK_START, vblank);
		checkValue("chbl", hCount >= `LSPC_CHBL_START, chbl);
		checkValue("hsync", hCount < `LSPC_HSYNC_END, hsync);
	endtask

	// Half-tile 1 of the entry's column, on a line of its row
	task automatic checkFixEntry(input int i);
		@(posedge CLK_24M);
		while (!(vCount[7:3] == fixRow[i] && hCount[8:3] == fixCol[i] && hCount[2]))
			@(posedge CLK_24M);
		checkValue("fixPal", fixWord[i][15:12], fixPal);
		checkValue("fixRomAddr tile", fixWord[i][11:0], fixRomAddr[11:0]);
		checkValue("fixRomAddr row", vCount[2:0], fixRomAddr[14:12]);
		checkValue("fixRomAddr half", hCount[2], fixRomAddr[15]);
	endtask

	task automatic resetAndLineTiming();
		int n;
		repeat (5) @(posedge CLK_24M);
		RESETP <= 1'b0;
		@(posedge CLK_24M);
		checkValue("hCount", 0, hCount);
		checkValue("vCount", 0, vCount);
		checkValue("vramBusy", 0, vramBusy);
		n = 0;
		while (hsync)
		begin
			n++;
			@(posedge CLK_24M);
		end
		checkValue("hsync cycles", `LSPC_HSYNC_END * 4, n);
		countToWrap(n);     // Align to line 1
		countToWrap(n);
		checkValue("line cycles", LINE_CYCLES, n);
		checkValue("vCount", 2, vCount);
	endtask

	task automatic writeAutoIncReadback();
		logic [`LSPC_VRAM_AW-1:0] base;
		base = {3'b000, 12'(randomWord())};   // Clear of the fix map
		setMod(16'd1);
		setAddr(base);
		repeat (16) writeData(randomWord());
		setAddr(base);
		repeat (16)
		begin
			readCheck();
			writeData(shadow[tbAddr]);  // Same word back, steps and prefetches
		end
	endtask

	task automatic wrapModulo();
		logic [15:0] m;
		logic [15:0] v;
		logic [`LSPC_VRAM_AW-1:0] a;
		logic [`LSPC_VRAM_AW-1:0] b;
		m = randomWord() | 16'h0010;   // Step of 16 or more crosses 0x7FFF
		a = {12'hFFF, 3'(randomWord())};
		b = a + m[`LSPC_VRAM_AW-1:0];
		setMod(m);
		readReg(3'd2, v);
		checkValue("cpuDataOut modulo", m, v);
		setAddr(a);
		writeData(randomWord());
		writeData(randomWord());        // Lands on the wrapped address
		setAddr(b);
		readCheck();
		setAddr(a);
		readCheck();
	endtask

	task automatic fixFetchRows();
		for (int i = 0; i < 4; i++)
		begin
			fixCol[i] = 6'(randomWord() % 48);
			fixRow[i] = (i < 2) ? 5'(4 + i) : 5'(8 + i);   // Rows 4, 5, 10, 11
			fixWord[i] = randomWord();
			setAddr({`LSPC_FIX_BASE, fixCol[i], fixRow[i]});
			writeData(fixWord[i]);
		end
		checkFixEntry(0);
		checkFixEntry(1);
	endtask

	// CPU traffic keeps running while the fetcher walks rows 10 and 11
	task automatic cpuFixContention();
		fixDone = 1'b0;
		fork
			begin
				checkFixEntry(2);
				checkFixEntry(3);
				fixDone = 1'b1;
			end
			begin
				setMod(16'd1);
				setAddr(15'h1000);
				repeat (8) writeData(randomWord());
				while (!fixDone)
				begin
					setAddr(15'h1000);
					repeat (8)
					begin
						readCheck();
						writeData(randomWord());
					end
				end
			end
		join
	endtask

	task automatic blankingAndMode();
		logic [15:0] mode;
		while (vCount != `LSPC_VBLANK_START - 1)
			@(posedge CLK_24M);
		while (vCount != `LSPC_VBLANK_START)
		begin
			checkRasterFlags();
			@(posedge CLK_24M);
		end
		checkValue("vblank", 1, vblank);
		readReg(3'd3, mode);
		checkValue("mode word", `LSPC_VBLANK_START << 7, mode);
		while (vCount == `LSPC_VBLANK_START)
		begin
			checkRasterFlags();
			@(posedge CLK_24M);
		end
	endtask

	initial
	begin
		seed = 91933;
		cycleCount = 0;
		RESETP = 1'b1;
		cpuAddr = 3'd0;
		cpuDataIn = 16'h0000;
		cpuWe = 1'b0;
		cpuOe = 1'b0;
		fixDone = 1'b0;
		resetAndLineTiming();
		writeAutoIncReadback();
		wrapModulo();
		fixFetchRows();
		cpuFixContention();
		blankingAndMode();
		$display(">>> PASS");
		$finish;
	end

endmodule

/* all.f */
+incdir+source
source/timingPkg.sv
source/vramPkg.sv
source/videoSync.sv
source/vramSlow.sv
source/slowCycle.sv
source/lspcRegs.sv
source/fixFetch.sv
source/lspcTop.sv
verif/lspcTb.sv
